// ==== hw/mmuRegPkg.sv ====
/*
	MMU register layouts
	Keyring slot geometry, status register user bit and
	operation code flag positions used by the permission checker.
*/
`default_nettype none

package mmuRegPkg;

	// Keyring register, four 16-bit key slots
	localparam int keySlotCount = 4;
	localparam int keySlotWidth = 16;	// Zero slot is disabled

	// A key and an owner ID split the same way
	localparam int keyGroupWidth = 6;	// Upper part
	localparam int keyUserWidth = 10;	// Lower part

	// Status register
	localparam int srUserBit = 30;		// Supervisor when set

	// Operation code, size in the low bits
	localparam int opmWriteBit = 4;
	localparam int opmReadBit = 3;

endpackage

`default_nettype wire

// ==== hw/mmuAccPkg.sv ====
/*
	Access mode definitions
	Field layout of the TLB access mode word, keyring check modes,
	permission classes and the exception codes raised on a denied access.
*/
`default_nettype none

package mmuAccPkg;

	localparam int accWordWidth = 32;

	// Access mode word fields, low bit of each
	localparam int accOwnerLsb = 16;	// Owner ID, group and user
	localparam int accOtherLsb = 13;
	localparam int accGroupLsb = 10;
	localparam int accUserLsb = 7;
	localparam int accModeLsb = 4;		// Keyring check mode
	localparam int accBaseLsb = 0;

	localparam int permWidth = 3;
	localparam int keyModeWidth = 3;

	// Base access bits, relative to accBaseLsb
	localparam int baseNoUserBit = 3;
	localparam int baseNoWriteBit = 1;
	localparam int baseNoReadBit = 0;

	// Bits within a permission triple
	localparam int permWriteBit = 1;
	localparam int permReadBit = 0;

	typedef enum logic [keyModeWidth-1:0] {
		keyModeOpen   = 3'd0,	// Any read or write faults
		keyModeCheck  = 3'd1,
		keyModeLocked = 3'd2,	// Always key fault
		keyModeStrict = 3'd3
	} keyModeE;

	typedef enum logic [1:0] {
		classUser,
		classGroup,
		classOther
	} permClassE;

	typedef enum logic [15:0] {
		excNone       = 16'h0000,
		excReadFault  = 16'h8001,
		excWriteFault = 16'h8002,
		excKeyFault   = 16'hA002
	} excCodeE;

endpackage

`default_nettype wire

// ==== hw/accDecode.sv ====
/*
	Access check decode stage
	Matches the enabled keyring slots against the page owner ID,
	picks the user, group or other permission triple and registers
	the decoded request for the execute stage.
*/
`timescale 1ns/10ps
`default_nettype none

module accDecode
	import mmuRegPkg::*, mmuAccPkg::*;
(
	input  logic                                 clock,
	input  logic                                 arstN,
	input  logic                                 reqValid,
	input  logic [accWordWidth-1:0]              tlbAcc,
	input  logic [keySlotCount*keySlotWidth-1:0] keyRing,
	input  logic                                 supervisor,
	input  logic [4:0]                           opm,
	output logic                                 decValid,
	output logic                                 keyEnable,
	output keyModeE                              keyMode,
	output logic [permWidth-1:0]                 perm,
	output logic                                 baseNoUser,
	output logic                                 baseNoWrite,
	output logic                                 baseNoRead,
	output logic                                 wantRead,
	output logic                                 wantWrite,
	output logic                                 supervisorOut
);

	logic [keySlotWidth-1:0]  ownerId;
	logic [keySlotCount-1:0]  slotEnable;
	logic [keySlotCount-1:0]  groupHit;	// Group match per slot
	logic [keySlotCount-1:0]  userHit;		// Group and user match per slot
	permClassE                permClass;
	logic [permWidth-1:0]     permSel;

	assign ownerId = tlbAcc[accOwnerLsb +: keySlotWidth];

	always_comb begin
		logic [keySlotWidth-1:0] slot;
		for (int i = 0; i < keySlotCount; i++) begin
			slot = keyRing[i*keySlotWidth +: keySlotWidth];
			slotEnable[i] = |slot;
			groupHit[i] = slotEnable[i] &&
				(slot[keyUserWidth +: keyGroupWidth] == ownerId[keyUserWidth +: keyGroupWidth]);
			userHit[i] = groupHit[i] &&
				(slot[0 +: keyUserWidth] == ownerId[0 +: keyUserWidth]);
		end
	end

	// User hit beats group hit beats other
	always_comb begin
		if (|userHit)
			permClass = classUser;
		else if (|groupHit)
			permClass = classGroup;
		else
			permClass = classOther;
	end

	always_comb begin
		case (permClass)
			classUser:  permSel = tlbAcc[accUserLsb +: permWidth];
			classGroup: permSel = tlbAcc[accGroupLsb +: permWidth];
			default:    permSel = tlbAcc[accOtherLsb +: permWidth];
		endcase
	end

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			decValid <= 1'b0;
		end else begin
			decValid <= reqValid;
		end
	end

	// Decoded payload
	always_ff @(posedge clock) begin
		keyEnable <= slotEnable[0];	// Slot A gates keyring checks
		keyMode <= keyModeE'(tlbAcc[accModeLsb +: keyModeWidth]);
		perm <= permSel;
		baseNoUser <= tlbAcc[accBaseLsb + baseNoUserBit];
		baseNoWrite <= tlbAcc[accBaseLsb + baseNoWriteBit];
		baseNoRead <= tlbAcc[accBaseLsb + baseNoReadBit];
		wantRead <= opm[opmReadBit];
		wantWrite <= opm[opmWriteBit];
		supervisorOut <= supervisor;
	end

endmodule

`default_nettype wire

// ==== hw/accExecute.sv ====
/*
	Access check execute stage
	Applies the keyring mode to the selected permission triple, then
	the base access bits, and registers the resulting exception code.
*/
`timescale 1ns/10ps
`default_nettype none

module accExecute
	import mmuAccPkg::*;
(
	input  logic                 clock,
	input  logic                 arstN,
	input  logic                 decValid,
	input  logic                 keyEnable,
	input  keyModeE              keyMode,
	input  logic [permWidth-1:0] perm,
	input  logic                 baseNoUser,
	input  logic                 baseNoWrite,
	input  logic                 baseNoRead,
	input  logic                 wantRead,
	input  logic                 wantWrite,
	input  logic                 supervisor,
	output logic                 exeValid,
	output excCodeE              exeExc
);

	logic    writeDenied;
	logic    readDenied;
	logic    userDeny;
	excCodeE keyExc;
	excCodeE nextExc;

	assign writeDenied = wantWrite && !perm[permWriteBit];
	assign readDenied = wantRead && !perm[permReadBit];

	always_comb begin
		keyExc = excNone;
		if (keyEnable) begin
			case (keyMode)
				keyModeOpen: begin
					if (wantWrite)
						keyExc = excWriteFault;
					if (wantRead)
						keyExc = excReadFault;	// Read wins
				end
				keyModeCheck: begin
					if (writeDenied)
						keyExc = excWriteFault;
					if (readDenied)
						keyExc = excReadFault;
				end
				keyModeStrict: begin
					if (writeDenied || readDenied)
						keyExc = excKeyFault;
				end
				default: keyExc = excKeyFault;	// Locked and undefined modes
			endcase
		end
	end

	// Base bits override whatever the keyring decided
	assign userDeny = baseNoUser && !supervisor;

	always_comb begin
		nextExc = keyExc;
		if (wantWrite && (baseNoWrite || userDeny))
			nextExc = excWriteFault;
		if (wantRead && (baseNoRead || userDeny))
			nextExc = excReadFault;
	end

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			exeValid <= 1'b0;
		end else begin
			exeValid <= decValid;
		end
	end

	always_ff @(posedge clock) begin
		exeExc <= nextExc;
	end

endmodule

`default_nettype wire

// ==== hw/accResult.sv ====
/*
	Access check result stage
	Registers the response and holds the first fault code
	until software acknowledges it.
*/
`timescale 1ns/10ps
`default_nettype none

module accResult
	import mmuAccPkg::*;
(
	input  logic    clock,
	input  logic    arstN,
	input  logic    exeValid,
	input  excCodeE exeExc,
	input  logic    faultAck,
	output logic    rspValid,
	output excCodeE rspExc,
	output logic    faultValid,
	output excCodeE faultCode
);

	logic newFault;

	assign newFault = exeValid && (exeExc != excNone);

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			rspValid <= 1'b0;
		end else begin
			rspValid <= exeValid;
		end
	end

	always_ff @(posedge clock) begin
		rspExc <= exeExc;
	end

	// Latch is open when empty or being acknowledged
	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			faultValid <= 1'b0;
			faultCode <= excNone;
		end else if (!faultValid || faultAck) begin
			if (newFault) begin
				faultValid <= 1'b1;	// Also re-latch during ack
				faultCode <= exeExc;
			end else begin
				faultValid <= 1'b0;
				faultCode <= excNone;
			end
		end
	end

endmodule

`default_nettype wire

// ==== hw/mmuAccCheck.sv ====
/*
	MMU page permission checker
	Three stage pipeline of decode, execute and result with a
	first-fault latch on the response side.
*/
`timescale 1ns/10ps
`default_nettype none

module mmuAccCheck
	import mmuRegPkg::*, mmuAccPkg::*;
(
	input  logic                                 clock,
	input  logic                                 arstN,
	input  logic                                 reqValid,
	input  logic [accWordWidth-1:0]              tlbAcc,
	input  logic [keySlotCount*keySlotWidth-1:0] keyRing,
	input  logic                                 supervisor,
	input  logic [4:0]                           opm,
	output logic                                 rspValid,
	output excCodeE                              rspExc,
	output logic                                 faultValid,
	output excCodeE                              faultCode,
	input  logic                                 faultAck
);

	// Decode to execute
	logic                 decValid;
	logic                 keyEnable;
	keyModeE              keyMode;
	logic [permWidth-1:0] perm;
	logic                 baseNoUser;
	logic                 baseNoWrite;
	logic                 baseNoRead;
	logic                 wantRead;
	logic                 wantWrite;
	logic                 decSupervisor;

	// Execute to result
	logic                 exeValid;
	excCodeE              exeExc;

	accDecode u_accDecode (
		.clock         (clock),
		.arstN         (arstN),
		.reqValid      (reqValid),
		.tlbAcc        (tlbAcc),
		.keyRing       (keyRing),
		.supervisor    (supervisor),
		.opm           (opm),
		.decValid      (decValid),
		.keyEnable     (keyEnable),
		.keyMode       (keyMode),
		.perm          (perm),
		.baseNoUser    (baseNoUser),
		.baseNoWrite   (baseNoWrite),
		.baseNoRead    (baseNoRead),
		.wantRead      (wantRead),
		.wantWrite     (wantWrite),
		.supervisorOut (decSupervisor)
	);

	accExecute u_accExecute (
		.clock       (clock),
		.arstN       (arstN),
		.decValid    (decValid),
		.keyEnable   (keyEnable),
		.keyMode     (keyMode),
		.perm        (perm),
		.baseNoUser  (baseNoUser),
		.baseNoWrite (baseNoWrite),
		.baseNoRead  (baseNoRead),
		.wantRead    (wantRead),
		.wantWrite   (wantWrite),
		.supervisor  (decSupervisor),
		.exeValid    (exeValid),
		.exeExc      (exeExc)
	);

	accResult u_accResult (
		.clock      (clock),
		.arstN      (arstN),
		.exeValid   (exeValid),
		.exeExc     (exeExc),
		.faultAck   (faultAck),
		.rspValid   (rspValid),
		.rspExc     (rspExc),
		.faultValid (faultValid),
		.faultCode  (faultCode)
	);

endmodule

`default_nettype wire

// ==== verif/mmuAccCheck_properties.sv ====
/*
	Access checker assertions
	Response latency, first-fault latch contents and the reset state
	of every pipeline valid.
*/
`timescale 1ns/10ps
`default_nettype none

module mmuAccCheckProperties
	import mmuAccPkg::*;
(
	input logic    clock,
	input logic    arstN,
	input logic    reqValid,
	input logic    decValid,
	input logic    exeValid,
	input logic    rspValid,
	input logic    faultValid,
	input excCodeE faultCode
);

	// Fixed three stage latency, no back-pressure
	assert property (@(posedge clock) disable iff (!arstN)
		rspValid == $past(reqValid, 3))
		else $error("rspValid does not follow reqValid by three cycles");

	assert property (@(posedge clock) disable iff (!arstN)
		faultValid |-> (faultCode != excNone))
		else $error("Fault latch holds excNone while valid");

	assert property (@(posedge clock)
		!arstN |-> (!decValid && !exeValid && !rspValid && !faultValid))
		else $error("A valid is high during reset");

endmodule

`default_nettype wire

// ==== verif/tbMmuAccCheck.sv ====
/*
	MMU access checker testbench
	Random requests from a fixed seed, checked in order against a
	reference model of the permission rules and the first-fault latch.
*/
`timescale 1ns/10ps
`default_nettype none

module tbMmuAccCheck
	import mmuRegPkg::*, mmuAccPkg::*;
;

	logic        clock;
	logic        arstN;
	logic        reqValid;
	logic [31:0] tlbAcc;
	logic [63:0] keyRing;
	logic        supervisor;
	logic [4:0]  opm;
	logic        faultAck;
	logic        rspValid;
	excCodeE     rspExc;
	logic        faultValid;
	excCodeE     faultCode;

	excCodeE     expQ[$];	// Expected codes in order
	int          dueQ[$];	// Cycle each response is due
	int          cycle = 0;
	logic        mFaultValid = 1'b0;
	excCodeE     mFaultCode = excNone;
	logic        ackSeen = 1'b0;		// faultAck as sampled by the DUT

	mmuAccCheck u_mmuAccCheck (
		.clock      (clock),
		.arstN      (arstN),
		.reqValid   (reqValid),
		.tlbAcc     (tlbAcc),
		.keyRing    (keyRing),
		.supervisor (supervisor),
		.opm        (opm),
		.rspValid   (rspValid),
		.rspExc     (rspExc),
		.faultValid (faultValid),
		.faultCode  (faultCode),
		.faultAck   (faultAck)
	);

	bind mmuAccCheck mmuAccCheckProperties u_mmuAccCheckProperties (
		.clock      (clock),
		.arstN      (arstN),
		.reqValid   (reqValid),
		.decValid   (decValid),
		.exeValid   (exeValid),
		.rspValid   (rspValid),
		.faultValid (faultValid),
		.faultCode  (faultCode)
	);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	always @(posedge clock) cycle <= cycle + 1;

	task automatic abortRun(input string reason);
		$display("%s", reason);
		$display("Simulation FAILED");
		$fatal(1, "Stopping on first error");
	endtask

	task automatic checkExc(input excCodeE got, input excCodeE exp);
		if (got !== exp)
			abortRun($sformatf("Fail at %0t: rspExc %h, expected %h", $time, got, exp));
	endtask

	task automatic checkFault(input logic gotValid, input excCodeE gotCode,
		input logic expValid, input excCodeE expCode);
		if (gotValid !== expValid || gotCode !== expCode)
			abortRun($sformatf("Fail at %0t: fault latch %b/%h, expected %b/%h",
				$time, gotValid, gotCode, expValid, expCode));
	endtask

	// Reference model of the permission rules
	function automatic excCodeE modelExc(input logic [31:0] acc, input logic [63:0] keys,
		input logic sup, input logic [4:0] op);
		logic [15:0] key;
		logic        anyUser;
		logic        anyGroup;
		logic [2:0]  trip;
		logic        rd;
		logic        wr;
		logic        rdDenied;
		logic        wrDenied;
		logic        userPage;
		excCodeE     code;
		anyUser = 1'b0;
		anyGroup = 1'b0;
		for (int s = 0; s < keySlotCount; s++) begin
			key = keys[s*16 +: 16];
			if (key != 16'h0 && key[15:10] == acc[31:26]) begin
				anyGroup = 1'b1;
				if (key[9:0] == acc[25:16])
					anyUser = 1'b1;
			end
		end
		trip = anyUser ? acc[9:7] : (anyGroup ? acc[12:10] : acc[15:13]);
		rd = op[3];
		wr = op[4];
		rdDenied = rd && !trip[0];
		wrDenied = wr && !trip[1];
		code = excNone;
		if (keys[15:0] != 16'h0) begin		// Slot A enables the keyring
			if (acc[6:4] == 3'd0) begin
				if (rd)
					code = excReadFault;
				else if (wr)
					code = excWriteFault;
			end else if (acc[6:4] == 3'd1) begin
				if (rdDenied)
					code = excReadFault;
				else if (wrDenied)
					code = excWriteFault;
			end else if (acc[6:4] == 3'd3) begin
				if (rdDenied || wrDenied)
					code = excKeyFault;
			end else begin
				code = excKeyFault;
			end
		end
		userPage = acc[3] && !sup;
		if (rd && (acc[0] || userPage))
			code = excReadFault;
		else if (wr && (acc[1] || userPage))
			code = excWriteFault;
		return code;
	endfunction

	function automatic logic [31:0] packAcc(input logic [15:0] owner, input logic [2:0] other,
		input logic [2:0] group, input logic [2:0] user, input logic [2:0] mode,
		input logic [3:0] base);
		return {owner, other, group, user, mode, base};
	endfunction

	// Kind 0 hits user, 1 hits group, 2 misses; slot A always enabled
	function automatic logic [63:0] keysFor(input logic [15:0] owner, input int kind,
		input logic [1:0] slot);
		logic [15:0] missKey;
		logic [15:0] hitKey;
		logic [63:0] keys;
		missKey = {~owner[15:10], owner[9:0] | 10'h001};
		if (kind == 0)
			hitKey = owner;
		else if (kind == 1)
			hitKey = {owner[15:10], ~owner[9:0]};
		else
			hitKey = missKey;
		keys = {4{missKey}};
		keys[int'(slot)*16 +: 16] = hitKey;
		return keys;
	endfunction

	// Response, fault latch and request monitor, sampled mid cycle
	always @(negedge clock) begin
		excCodeE want;
		logic    gotRsp;
		want = excNone;
		gotRsp = 1'b0;
		if (!arstN) begin
			expQ.delete();
			dueQ.delete();
			mFaultValid = 1'b0;
			mFaultCode = excNone;
			ackSeen = 1'b0;
			if (rspValid !== 1'b0 || faultValid !== 1'b0 || faultCode !== excNone)
				abortRun("Outputs were not cleared while reset was asserted");
		end else begin
			if (rspValid === 1'b1) begin
				if (expQ.size() == 0) begin
					abortRun("A response arrived with no request outstanding");
				end else if (dueQ[0] != cycle) begin
					abortRun($sformatf("Fail at %0t: response due at cycle %0d came at %0d",
						$time, dueQ[0], cycle));
				end else begin
					want = expQ.pop_front();
					void'(dueQ.pop_front());
					gotRsp = 1'b1;
					checkExc(rspExc, want);
				end
			end else if (dueQ.size() != 0 && dueQ[0] <= cycle) begin
				abortRun($sformatf("Fail at %0t: no response at cycle %0d", $time, cycle));
			end
			if (!mFaultValid || ackSeen) begin	// Latch open
				mFaultValid = gotRsp && (want != excNone);
				mFaultCode = mFaultValid ? want : excNone;
			end
			checkFault(faultValid, faultCode, mFaultValid, mFaultCode);
			ackSeen = faultAck;
			if (reqValid === 1'b1) begin
				expQ.push_back(modelExc(tlbAcc, keyRing, supervisor, opm));
				dueQ.push_back(cycle + 3);	// Decode, execute and result stages
			end
		end
	end

	task automatic sendReq(input logic [31:0] acc, input logic [63:0] keys, input logic sup,
		input logic [4:0] op);
		@(posedge clock);
		reqValid <= 1'b1;
		tlbAcc <= acc;
		keyRing <= keys;
		supervisor <= sup;
		opm <= op;
	endtask

	task automatic idleCycles(input int n);
		for (int i = 0; i < n; i++) begin
			@(posedge clock);
			reqValid <= 1'b0;
		end
	endtask

	task automatic drainResponses();
		int waited;
		waited = 0;
		idleCycles(1);
		while (expQ.size() != 0 && waited < 12) begin
			@(posedge clock);
			waited++;
		end
		if (expQ.size() != 0)
			abortRun("Timeout while waiting for outstanding responses");
	endtask

	task automatic waitForFaultState(input logic want, input string what);
		int waited;
		waited = 0;
		@(negedge clock);
		while (faultValid !== want && waited < 16) begin
			@(negedge clock);
			waited++;
		end
		if (faultValid !== want)
			abortRun({"Timeout waiting for the fault latch to ", what});
	endtask

	task automatic pulseReset(input int n);
		@(posedge clock);
		arstN <= 1'b0;
		reqValid <= 1'b0;
		faultAck <= 1'b0;
		repeat (n) @(posedge clock);
		arstN <= 1'b1;
	endtask

	task automatic runBaseOnly(input int n);
		logic [31:0] r;
		for (int i = 0; i < n; i++) begin
			r = $urandom;
			sendReq($urandom, 64'h0, r[0], r[5:1]);	// Keyring off
		end
		drainResponses();
	endtask

	task automatic runClassSelect(input int n);
		logic [31:0] r;
		logic [31:0] ro;
		logic [15:0] owner;
		logic [2:0]  mode;
		for (int i = 0; i < n; i++) begin
			r = $urandom;
			ro = $urandom;
			owner = r[15:0] | 16'h0400;	// Nonzero group keeps hit keys enabled
			mode = r[18] ? keyModeStrict : keyModeCheck;
			sendReq(packAcc(owner, r[21:19], r[24:22], r[27:25], mode, {1'b0, r[28], 2'b00}),
				keysFor(owner, int'(r[17:16]) % 3, r[30:29]), r[31], ro[4:0]);
		end
		drainResponses();
	endtask

	task automatic runKeyModes(input int n);
		logic [31:0] r;
		logic [31:0] ro;
		logic [63:0] keys;
		logic [2:0]  mode;
		for (int i = 0; i < n; i++) begin
			r = $urandom;
			keys = {$urandom, $urandom};
			ro = $urandom;
			keys[0] = 1'b1;
			mode = r[22:20];
			if (mode == keyModeCheck || mode == keyModeStrict)
				mode = keyModeLocked;
			sendReq(packAcc(r[15:0], r[18:16], r[25:23], r[28:26], mode, 4'b0000),
				keys, r[29], ro[4:0]);
		end
		drainResponses();
	endtask

	task automatic randomTraffic(input int n, input logic withAck);
		logic [31:0] r;
		logic [31:0] acc;
		logic [63:0] keys;
		for (int i = 0; i < n; i++) begin
			r = $urandom;
			acc = $urandom;
			keys = {$urandom, $urandom};
			if (r[0])
				keys[15:0] = 16'h0000;
			if (r[1])
				keys[int'(r[3:2])*16 +: 16] = acc[31:16];
			else if (r[4])
				keys[int'(r[3:2])*16 +: 16] = {acc[31:26], r[14:5]};
			sendReq(acc, keys, r[15], r[20:16]);
			faultAck <= withAck && (r[23:21] == 3'b000);
			if (r[25:24] == 2'b00)
				idleCycles(int'(r[27:26]) + 1);	// Idle gap
		end
		faultAck <= 1'b0;
	endtask

	task automatic runFaultLatch();
		logic [31:0] readAcc;
		logic [31:0] writeAcc;
		readAcc = packAcc(16'h0, 3'b111, 3'b111, 3'b111, 3'd0, 4'b0001);
		writeAcc = packAcc(16'h0, 3'b111, 3'b111, 3'b111, 3'd0, 4'b0010);
		@(posedge clock);
		faultAck <= 1'b1;
		@(posedge clock);
		faultAck <= 1'b0;
		waitForFaultState(1'b0, "clear before the latch test");
		sendReq(writeAcc, 64'h0, 1'b1, 5'b10000);
		sendReq(readAcc, 64'h0, 1'b1, 5'b01000);
		sendReq(writeAcc, 64'h0, 1'b1, 5'b10000);
		idleCycles(1);
		waitForFaultState(1'b1, "set on the first fault");
		for (int i = 0; i < 8; i++) begin
			sendReq(i[0] ? readAcc : writeAcc, 64'h0, 1'b1, i[0] ? 5'b01000 : 5'b10000);
			if (i == 3)
				faultAck <= 1'b1;	// Ack lands while faults keep coming
			else
				faultAck <= 1'b0;
		end
		drainResponses();
		@(posedge clock);
		faultAck <= 1'b1;
		@(posedge clock);
		faultAck <= 1'b0;
		waitForFaultState(1'b0, "clear after acknowledge");
	endtask

	initial begin
		void'($urandom(78465));
		arstN = 1'b1;
		reqValid = 1'b0;
		tlbAcc = 32'h0;
		keyRing = 64'h0;
		supervisor = 1'b0;
		opm = 5'h0;
		faultAck = 1'b0;
		#5 arstN = 1'b0;
		repeat (8) @(posedge clock);
		arstN <= 1'b1;

		runBaseOnly(60);
		runClassSelect(80);
		runKeyModes(60);
		randomTraffic(300, 1'b1);
		drainResponses();
		runFaultLatch();

		randomTraffic(12, 1'b1);	// Reset with requests in flight
		pulseReset(4);
		randomTraffic(60, 1'b1);
		drainResponses();

		idleCycles(4);
		$display("Simulation PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== list.f ====
hw/mmuRegPkg.sv
hw/mmuAccPkg.sv
hw/accDecode.sv
hw/accExecute.sv
hw/accResult.sv
hw/mmuAccCheck.sv
verif/mmuAccCheck_properties.sv
verif/tbMmuAccCheck.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the MMU access checker testbench with Verilator.
# The exit status is the verdict: any $fatal in the run ends non-zero.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tbMmuAccCheck -f list.f \
	&& ./obj_dir/VtbMmuAccCheck \
	|| { echo "MMU access checker run did not complete cleanly"; exit 1; }
